// File: hw/sa_pkg.sv
// shared codes, register map and structs for the sample-acquisition front end
// switch codes assume PC BOOT is 0 and the AZ mux PC-OUT input is S1 (4'b1000)
// timing counts are in clk cycles and a phase lasts count+2 cycles
package sa_pkg;

  // pre-charge switch positions
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  // az mux code width and the PC-OUT select
  localparam int                 AZMUX_W      = 4;
  localparam logic [AZMUX_W-1:0] AZMUX_PC_OUT = 4'b1000;

  // timing and status widths
  localparam int CNT_W      = 32;
  localparam int PRE_W      = 24;
  localparam int MON_W      = 8;
  localparam int STAT_CNT_W = 16;

  ////////////////////
  // apb register map
  localparam int              APB_AW        = 12;
  localparam int              APB_DW        = 32;
  localparam logic [APB_AW-1:0] REG_CTRL      = 12'h000;
  localparam logic [APB_AW-1:0] REG_SAMPLE    = 12'h004;
  localparam logic [APB_AW-1:0] REG_PRECHARGE = 12'h008;
  localparam logic [APB_AW-1:0] REG_STATUS    = 12'h00C;

  typedef enum logic {
    MODE_PC_TEST = 1'b0,
    MODE_AZ      = 1'b1
  } sa_mode_e;

  typedef struct packed {
    logic [CNT_W-1:0] sample_duration;
    logic [PRE_W-1:0] precharge;
  } sa_timing_t;

  // physical switch command
  typedef struct packed {
    logic               pc;
    logic [AZMUX_W-1:0] azmux;
  } sa_switch_t;

  // what a sequencer offers to the arbiter
  typedef struct packed {
    sa_switch_t       sw;
    logic             led;
    logic [MON_W-1:0] monitor;
    logic             cycle_done;
  } sa_seq_out_t;

  typedef struct packed {
    logic [AZMUX_W-1:0] azmux_lo;
    sa_mode_e           mode;
    logic               run;
  } sa_ctrl_t;

  // switches parked with the signal protected
  localparam sa_switch_t SW_SAFE = '{pc: SW_PC_BOOT, azmux: AZMUX_PC_OUT};

  // phase engine states, each timed phase is a load state and a wait state
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_PROTECT_LD,
    ST_PROTECT_WAIT,
    ST_SETTLE_LD,
    ST_SETTLE_WAIT,
    ST_HI_LD,
    ST_HI_WAIT,
    ST_REPROT_LD,
    ST_REPROT_WAIT,
    ST_LO_LD,
    ST_LO_WAIT,
    ST_END
  } sa_phase_e;

endpackage

// File: hw/sa_apb_regs.sv
// apb3 slave with zero wait states, writes land on the cycle after the access phase
// unmapped addresses and writes to status return pslverr for that access only
// the completed-cycle count saturates at 16'hffff
module sa_apb_regs (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic [sa_pkg::APB_AW-1:0]    paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [sa_pkg::APB_DW-1:0]    pwdata_i,
  input  logic                         cycle_pulse_i,
  input  sa_pkg::sa_mode_e             owner_i,
  output logic [sa_pkg::APB_DW-1:0]    prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output sa_pkg::sa_ctrl_t             ctrl_o,
  output sa_pkg::sa_timing_t           timing_o
);

  logic                              access;
  logic                              wr_en;
  logic                              hit_ctrl;
  logic                              hit_sample;
  logic                              hit_pre;
  logic                              hit_status;
  logic                              hit_any;
  sa_pkg::sa_ctrl_t                  ctrl_q;
  sa_pkg::sa_timing_t                timing_q;
  logic [sa_pkg::STAT_CNT_W-1:0]     cycle_cnt_q;

  ////////////////////
  // address decode

  // access phase of a transfer
  assign access = psel_i && penable_i;

  assign hit_ctrl   = (paddr_i == sa_pkg::REG_CTRL);
  assign hit_sample = (paddr_i == sa_pkg::REG_SAMPLE);
  assign hit_pre    = (paddr_i == sa_pkg::REG_PRECHARGE);
  assign hit_status = (paddr_i == sa_pkg::REG_STATUS);
  assign hit_any    = hit_ctrl || hit_sample || hit_pre || hit_status;

  // status is read only so a write there is dropped
  assign wr_en = access && pwrite_i && !hit_status;

  // no wait states
  assign pready_o = 1'b1;

  // error only flagged in the access phase
  assign pslverr_o = access && (!hit_any || (pwrite_i && hit_status));

  ////////////////////
  // register write

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      ctrl_q   <= '0;
      timing_q <= '0;
    end
    else if (wr_en)
    begin
      if (hit_ctrl)
      begin
        ctrl_q.run      <= pwdata_i[0];
        ctrl_q.mode     <= sa_pkg::sa_mode_e'(pwdata_i[1]);
        // bits 3:2 reserved
        ctrl_q.azmux_lo <= pwdata_i[7:4];
      end
      if (hit_sample)
      begin
        timing_q.sample_duration <= pwdata_i;
      end
      if (hit_pre)
      begin
        // upper byte ignored
        timing_q.precharge <= pwdata_i[sa_pkg::PRE_W-1:0];
      end
    end
  end

  // completed cycles as reported by the arbiter
  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      cycle_cnt_q <= '0;
    end
    else if (cycle_pulse_i && (cycle_cnt_q != '1))
    begin
      cycle_cnt_q <= cycle_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // read mux

  always_comb
  begin
    prdata_o = '0;
    case (paddr_i)
      sa_pkg::REG_CTRL:
        prdata_o = {24'b0, ctrl_q.azmux_lo, 2'b0, ctrl_q.mode, ctrl_q.run};
      sa_pkg::REG_SAMPLE:
        prdata_o = timing_q.sample_duration;
      sa_pkg::REG_PRECHARGE:
        prdata_o = {{(sa_pkg::APB_DW - sa_pkg::PRE_W){1'b0}}, timing_q.precharge};
      sa_pkg::REG_STATUS:
        prdata_o = {cycle_cnt_q, 15'b0, owner_i};
      default:
        prdata_o = '0;
    endcase
  end

  assign ctrl_o   = ctrl_q;
  assign timing_o = timing_q;

  // the bus master never raises penable outside a selected transfer
  a_penable_in_sel : assert property (@(posedge clk) disable iff (reset_n)
    penable_i |-> psel_i);

endmodule

// File: hw/sa_pc_sequencer.sv
// charge-test sequencer, toggles only the pre-charge switch
// the az mux stays parked on PC-OUT so the hi input is seen through the PC switch
// timing is sampled at each phase load so register writes apply from the next phase
module sa_pc_sequencer (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  en_i,
  input  sa_pkg::sa_timing_t    timing_i,
  output sa_pkg::sa_seq_out_t   seq_o
);

  sa_pkg::sa_phase_e               state_q;
  logic [sa_pkg::CNT_W-1:0]        count_q;
  logic [sa_pkg::CNT_W-1:0]        pre_ext;
  logic                            count_zero;
  logic                            pc_q;
  logic                            led_q;
  logic [sa_pkg::MON_W-1:0]        mon_q;

  // precharge count widened to the counter
  assign pre_ext    = {{(sa_pkg::CNT_W - sa_pkg::PRE_W){1'b0}}, timing_i.precharge};
  assign count_zero = (count_q == '0);

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      state_q <= sa_pkg::ST_IDLE;
      count_q <= '0;
      pc_q    <= sa_pkg::SW_PC_BOOT;
      led_q   <= 1'b0;
      mon_q   <= '0;
    end
    else if (!en_i)
    begin
      // parked with the signal protected
      state_q <= sa_pkg::ST_IDLE;
      pc_q    <= sa_pkg::SW_PC_BOOT;
      led_q   <= 1'b0;
      mon_q   <= '0;
    end
    else
    begin
      // free-running decrement, overridden by each phase load
      count_q <= count_q - 1'b1;
      case (state_q)
        // first enabled cycle acts as the start state
        sa_pkg::ST_IDLE:
          state_q <= sa_pkg::ST_PROTECT_LD;

        ////////////////////
        // protect the signal before anything else
        sa_pkg::ST_PROTECT_LD:
        begin
          state_q <= sa_pkg::ST_PROTECT_WAIT;
          count_q <= pre_ext;
          pc_q    <= sa_pkg::SW_PC_BOOT;
          mon_q   <= '0;
        end
        sa_pkg::ST_PROTECT_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_SETTLE_LD;

        // settle on boot, hi section starts here
        sa_pkg::ST_SETTLE_LD:
        begin
          state_q  <= sa_pkg::ST_SETTLE_WAIT;
          count_q  <= pre_ext;
          mon_q[0] <= 1'b1;
        end
        sa_pkg::ST_SETTLE_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_HI_LD;

        // pc onto signal for the hi sample
        sa_pkg::ST_HI_LD:
        begin
          state_q  <= sa_pkg::ST_HI_WAIT;
          count_q  <= timing_i.sample_duration;
          pc_q     <= sa_pkg::SW_PC_SIGNAL;
          led_q    <= 1'b1;
          mon_q[1] <= 1'b1;
        end
        sa_pkg::ST_HI_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_REPROT_LD;

        // back to boot
        sa_pkg::ST_REPROT_LD:
        begin
          state_q  <= sa_pkg::ST_REPROT_WAIT;
          count_q  <= pre_ext;
          pc_q     <= sa_pkg::SW_PC_BOOT;
          mon_q[1] <= 1'b0;
        end
        sa_pkg::ST_REPROT_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_LO_LD;

        ////////////////////
        // lo sample time, switches unchanged
        sa_pkg::ST_LO_LD:
        begin
          state_q  <= sa_pkg::ST_LO_WAIT;
          count_q  <= timing_i.sample_duration;
          led_q    <= 1'b0;
          mon_q[0] <= 1'b0;
        end
        sa_pkg::ST_LO_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_END;

        // cycle_done cycle, then straight into the next settle
        sa_pkg::ST_END:
          state_q <= sa_pkg::ST_SETTLE_LD;

        default:
          state_q <= sa_pkg::ST_IDLE;
      endcase
    end
  end

  assign seq_o.sw.pc      = pc_q;
  assign seq_o.sw.azmux   = sa_pkg::AZMUX_PC_OUT;
  assign seq_o.led        = led_q;
  assign seq_o.monitor    = mon_q;
  assign seq_o.cycle_done = (state_q == sa_pkg::ST_END);

  // signal time is confined to the hi phase and its closing load
  a_signal_in_hi : assert property (@(posedge clk) disable iff (reset_n)
    (pc_q == sa_pkg::SW_PC_SIGNAL) |->
      (state_q inside {sa_pkg::ST_HI_WAIT, sa_pkg::ST_REPROT_LD}));

endmodule

// File: hw/sa_az_sequencer.sv
// auto-zero sequencer, alternates hi and lo samples with the az mux and PC switch
// the az mux only moves while PC is at BOOT so charge injection misses the signal
// azmux_lo_i is sampled at the protect and lo loads
module sa_az_sequencer (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          en_i,
  input  sa_pkg::sa_timing_t            timing_i,
  input  logic [sa_pkg::AZMUX_W-1:0]    azmux_lo_i,
  output sa_pkg::sa_seq_out_t           seq_o
);

  sa_pkg::sa_phase_e               state_q;
  logic [sa_pkg::CNT_W-1:0]        count_q;
  logic [sa_pkg::CNT_W-1:0]        pre_ext;
  logic                            count_zero;
  sa_pkg::sa_switch_t              sw_q;
  logic                            led_q;
  logic [sa_pkg::MON_W-1:0]        mon_q;

  assign pre_ext    = {{(sa_pkg::CNT_W - sa_pkg::PRE_W){1'b0}}, timing_i.precharge};
  assign count_zero = (count_q == '0);

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      state_q <= sa_pkg::ST_IDLE;
      count_q <= '0;
      sw_q    <= sa_pkg::SW_SAFE;
      led_q   <= 1'b0;
      mon_q   <= '0;
    end
    else if (!en_i)
    begin
      state_q <= sa_pkg::ST_IDLE;
      sw_q    <= sa_pkg::SW_SAFE;
      led_q   <= 1'b0;
      mon_q   <= '0;
    end
    else
    begin
      count_q <= count_q - 1'b1;
      case (state_q)
        sa_pkg::ST_IDLE:
          state_q <= sa_pkg::ST_PROTECT_LD;

        ////////////////////
        // pc to boot, mux to lo while protected
        sa_pkg::ST_PROTECT_LD:
        begin
          state_q  <= sa_pkg::ST_PROTECT_WAIT;
          count_q  <= pre_ext;
          sw_q.pc  <= sa_pkg::SW_PC_BOOT;
          sw_q.azmux <= azmux_lo_i;
          mon_q    <= '0;
          // lo input selected
          mon_q[2] <= 1'b1;
        end
        sa_pkg::ST_PROTECT_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_SETTLE_LD;

        // mux from lo to PC-OUT, pc still on boot
        sa_pkg::ST_SETTLE_LD:
        begin
          state_q    <= sa_pkg::ST_SETTLE_WAIT;
          count_q    <= pre_ext;
          sw_q.azmux <= sa_pkg::AZMUX_PC_OUT;
          mon_q[0]   <= 1'b1;
          mon_q[2]   <= 1'b0;
        end
        sa_pkg::ST_SETTLE_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_HI_LD;

        // hi sample through the pc switch
        sa_pkg::ST_HI_LD:
        begin
          state_q  <= sa_pkg::ST_HI_WAIT;
          count_q  <= timing_i.sample_duration;
          sw_q.pc  <= sa_pkg::SW_PC_SIGNAL;
          led_q    <= 1'b1;
          mon_q[1] <= 1'b1;
        end
        sa_pkg::ST_HI_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_REPROT_LD;

        // protect again before the mux moves
        sa_pkg::ST_REPROT_LD:
        begin
          state_q  <= sa_pkg::ST_REPROT_WAIT;
          count_q  <= pre_ext;
          sw_q.pc  <= sa_pkg::SW_PC_BOOT;
          mon_q[1] <= 1'b0;
        end
        sa_pkg::ST_REPROT_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_LO_LD;

        ////////////////////
        // lo measurement
        sa_pkg::ST_LO_LD:
        begin
          state_q    <= sa_pkg::ST_LO_WAIT;
          count_q    <= timing_i.sample_duration;
          sw_q.azmux <= azmux_lo_i;
          led_q      <= 1'b0;
          mon_q[0]   <= 1'b0;
          mon_q[2]   <= 1'b1;
        end
        sa_pkg::ST_LO_WAIT:
          if (count_zero)
            state_q <= sa_pkg::ST_END;

        sa_pkg::ST_END:
          state_q <= sa_pkg::ST_SETTLE_LD;

        default:
          state_q <= sa_pkg::ST_IDLE;
      endcase
    end
  end

  assign seq_o.sw         = sw_q;
  assign seq_o.led        = led_q;
  assign seq_o.monitor    = mon_q;
  assign seq_o.cycle_done = (state_q == sa_pkg::ST_END);

  // mux edges only land while pc is on boot on both sides of the edge
  a_mux_quiet : assert property (@(posedge clk) disable iff (reset_n)
    !$stable(sw_q.azmux) |->
      (sw_q.pc == sa_pkg::SW_PC_BOOT) && ($past(sw_q.pc) == sa_pkg::SW_PC_BOOT));

endmodule

// File: hw/sa_switch_arbiter.sv
// hands the switch outputs to one sequencer at a time
// owner changes and run clears only take effect at the owner's cycle_done
// outputs are registered and park on BOOT and PC-OUT when nothing is granted
module sa_switch_arbiter (
  input  logic                          clk,
  input  logic                          reset_n,
  input  sa_pkg::sa_ctrl_t              ctrl_i,
  input  sa_pkg::sa_seq_out_t           pc_seq_i,
  input  sa_pkg::sa_seq_out_t           az_seq_i,
  output logic                          pc_en_o,
  output logic                          az_en_o,
  output sa_pkg::sa_mode_e              owner_o,
  output logic                          cycle_pulse_o,
  output logic                          sw_pc_ctl_o,
  output logic [sa_pkg::AZMUX_W-1:0]    azmux_o,
  output logic                          led0_o,
  output logic [sa_pkg::MON_W-1:0]      monitor_o
);

  sa_pkg::sa_mode_e      owner_q;
  logic                  granted_q;
  sa_pkg::sa_seq_out_t   sel;
  logic                  owner_done;

  // current owner's offer
  assign sel        = (owner_q == sa_pkg::MODE_AZ) ? az_seq_i : pc_seq_i;
  assign owner_done = granted_q && sel.cycle_done;

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      owner_q   <= sa_pkg::MODE_PC_TEST;
      granted_q <= 1'b0;
    end
    else if (!granted_q)
    begin
      // idle so a new run can start at once
      if (ctrl_i.run)
      begin
        granted_q <= 1'b1;
        owner_q   <= ctrl_i.mode;
      end
    end
    else if (owner_done)
    begin
      // cycle boundary where mode and run are picked up
      granted_q <= ctrl_i.run;
      if (ctrl_i.run)
        owner_q <= ctrl_i.mode;
    end
  end

  ////////////////////
  // output stage

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      sw_pc_ctl_o <= sa_pkg::SW_SAFE.pc;
      azmux_o     <= sa_pkg::SW_SAFE.azmux;
      led0_o      <= 1'b0;
      monitor_o   <= '0;
    end
    else if (granted_q)
    begin
      sw_pc_ctl_o <= sel.sw.pc;
      azmux_o     <= sel.sw.azmux;
      led0_o      <= sel.led;
      monitor_o   <= sel.monitor;
    end
    else
    begin
      sw_pc_ctl_o <= sa_pkg::SW_SAFE.pc;
      azmux_o     <= sa_pkg::SW_SAFE.azmux;
      led0_o      <= 1'b0;
      monitor_o   <= '0;
    end
  end

  assign pc_en_o       = granted_q && (owner_q == sa_pkg::MODE_PC_TEST);
  assign az_en_o       = granted_q && (owner_q == sa_pkg::MODE_AZ);
  assign owner_o       = owner_q;
  assign cycle_pulse_o = owner_done;

  a_one_enable : assert property (@(posedge clk) disable iff (reset_n)
    !(pc_en_o && az_en_o));

endmodule

// File: hw/sa_top.sv
// sample-acquisition front end with apb control of timing and mode
// run is taken as synchronous to clk
// first switch change comes a few cycles after the run write
module sa_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic [sa_pkg::APB_AW-1:0]     paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [sa_pkg::APB_DW-1:0]     pwdata_i,
  output logic [sa_pkg::APB_DW-1:0]     prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic                          sw_pc_ctl_o,
  output logic [sa_pkg::AZMUX_W-1:0]    azmux_o,
  output logic                          led0_o,
  output logic [sa_pkg::MON_W-1:0]      monitor_o
);

  sa_pkg::sa_ctrl_t      ctrl;
  sa_pkg::sa_timing_t    timing;
  sa_pkg::sa_seq_out_t   pc_seq;
  sa_pkg::sa_seq_out_t   az_seq;
  sa_pkg::sa_mode_e      owner;
  logic                  pc_en;
  logic                  az_en;
  logic                  cycle_pulse;

  // register block
  sa_apb_regs i_sa_apb_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .cycle_pulse_i (cycle_pulse),
    .owner_i       (owner),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .ctrl_o        (ctrl),
    .timing_o      (timing)
  );

  ////////////////////
  // peer sequencers

  sa_pc_sequencer i_sa_pc_sequencer (
    .clk      (clk),
    .reset_n  (reset_n),
    .en_i     (pc_en),
    .timing_i (timing),
    .seq_o    (pc_seq)
  );

  sa_az_sequencer i_sa_az_sequencer (
    .clk        (clk),
    .reset_n    (reset_n),
    .en_i       (az_en),
    .timing_i   (timing),
    .azmux_lo_i (ctrl.azmux_lo),
    .seq_o      (az_seq)
  );

  // single owner of the switch pins
  sa_switch_arbiter i_sa_switch_arbiter (
    .clk           (clk),
    .reset_n       (reset_n),
    .ctrl_i        (ctrl),
    .pc_seq_i      (pc_seq),
    .az_seq_i      (az_seq),
    .pc_en_o       (pc_en),
    .az_en_o       (az_en),
    .owner_o       (owner),
    .cycle_pulse_o (cycle_pulse),
    .sw_pc_ctl_o   (sw_pc_ctl_o),
    .azmux_o       (azmux_o),
    .led0_o        (led0_o),
    .monitor_o     (monitor_o)
  );

endmodule

// File: tb/sa_tb.sv
// random-stimulus testbench for the sample-acquisition front end
// phase lengths are predicted from the N+2 rule, with small random timing values
// a switch trace records edges with cycle stamps and the checks run against that trace
module sa_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 2000;

  logic                             clk;
  logic                             reset_n;
  logic [sa_pkg::APB_AW-1:0]        paddr_i;
  logic                             psel_i;
  logic                             penable_i;
  logic                             pwrite_i;
  logic [sa_pkg::APB_DW-1:0]        pwdata_i;
  logic [sa_pkg::APB_DW-1:0]        prdata_o;
  logic                             pready_o;
  logic                             pslverr_o;
  logic                             sw_pc_ctl_o;
  logic [sa_pkg::AZMUX_W-1:0]       azmux_o;
  logic                             led0_o;
  logic [sa_pkg::MON_W-1:0]         monitor_o;

  int unsigned errors;
  int unsigned timeouts;
  int unsigned pre_v;
  int unsigned samp_v;
  logic [3:0]  lo_v;

  // switch trace
  int unsigned cyc;
  int unsigned rise_cnt;
  int unsigned rise_t;
  int unsigned fall_t;
  logic        fall_valid;
  int unsigned az_chg_cnt;
  int unsigned seg_start;
  logic        prev_pc;
  logic [3:0]  prev_az;
  logic        prev_led;
  int unsigned width_q[$];
  int unsigned gap_q[$];
  logic [3:0]  seg_val_q[$];
  int unsigned seg_len_q[$];

  sa_top i_sa_top (
    .clk         (clk),
    .reset_n     (reset_n),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .sw_pc_ctl_o (sw_pc_ctl_o),
    .azmux_o     (azmux_o),
    .led0_o      (led0_o),
    .monitor_o   (monitor_o)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  ////////////////////
  // compare tasks

  task automatic check_switch(input string name, input sa_pkg::sa_switch_t got,
                              input sa_pkg::sa_switch_t exp);
  begin
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
  begin
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
  begin
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  end
  endtask

  // closing line, then the verdict
  task automatic finish_run();
  begin
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end
  endtask

  task automatic timed_out(input string what);
  begin
    $display("timeout while waiting for %s", what);
    timeouts++;
    finish_run();
  end
  endtask

  ////////////////////
  // apb driver

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic err);
  begin
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk);
    penable_i <= 1'b1;
    @(posedge clk);
    // access phase seen before the nba update
    err = pslverr_o;
    check_bit("pready_o", pready_o, 1'b1);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  end
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
  begin
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk);
    penable_i <= 1'b1;
    @(posedge clk);
    data = prdata_o;
    err  = pslverr_o;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  end
  endtask

  function automatic logic [31:0] ctrl_word(input logic run, input logic mode,
                                            input logic [3:0] lo);
    return {24'b0, lo, 2'b0, mode, run};
  endfunction

  ////////////////////
  // switch trace, sampled on the rising edge
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      cyc++;
      if (sw_pc_ctl_o !== prev_pc)
      begin
        if (sw_pc_ctl_o == sa_pkg::SW_PC_SIGNAL)
        begin
          rise_cnt++;
          rise_t = cyc;
          if (fall_valid)
            gap_q.push_back(cyc - fall_t);
          check_bit("led0_o at signal start", led0_o, 1'b1);
          // monitor marks the hi section and signal time
          check_bit("monitor_o[0] at signal start", monitor_o[0], 1'b1);
          check_bit("monitor_o[1] at signal start", monitor_o[1], 1'b1);
        end
        else
        begin
          width_q.push_back(cyc - rise_t);
          fall_t     = cyc;
          fall_valid = 1'b1;
          check_bit("monitor_o[1] at signal end", monitor_o[1], 1'b0);
        end
      end
      // led drops at the lo load, one protect phase after pc returns to boot
      if (prev_led && !led0_o && fall_valid)
      begin
        check_word("led0_o fall delay", cyc - fall_t, pre_v + 2);
        check_bit("monitor_o[0] at led fall", monitor_o[0], 1'b0);
      end
      if (azmux_o !== prev_az)
      begin
        az_chg_cnt++;
        check_bit("sw_pc_ctl_o at azmux edge", sw_pc_ctl_o, sa_pkg::SW_PC_BOOT);
        check_bit("prev sw_pc_ctl_o at azmux edge", prev_pc, sa_pkg::SW_PC_BOOT);
        seg_val_q.push_back(prev_az);
        seg_len_q.push_back(cyc - seg_start);
        seg_start = cyc;
      end
      prev_pc  = sw_pc_ctl_o;
      prev_az  = azmux_o;
      prev_led = led0_o;
    end
  end

  // bounded waits, all checked on the falling edge after the trace settles
  task automatic wait_widths(input int unsigned n);
    int unsigned i;
  begin
    i = 0;
    while (width_q.size() < n)
    begin
      @(negedge clk);
      i++;
      if (i > WAIT_LIMIT)
        timed_out("SIGNAL pulses");
    end
  end
  endtask

  task automatic wait_rise(input int unsigned cnt);
    int unsigned i;
  begin
    i = 0;
    while (rise_cnt <= cnt)
    begin
      @(negedge clk);
      i++;
      if (i > WAIT_LIMIT)
        timed_out("a rising edge on the PC switch");
    end
  end
  endtask

  task automatic wait_az_change(input int unsigned cnt);
    int unsigned i;
  begin
    i = 0;
    while (az_chg_cnt <= cnt)
    begin
      @(negedge clk);
      i++;
      if (i > WAIT_LIMIT)
        timed_out("an azmux change");
    end
  end
  endtask

  task automatic wait_idle();
    int unsigned i;
  begin
    i = 0;
    while (monitor_o != '0 || led0_o)
    begin
      @(negedge clk);
      i++;
      if (i > WAIT_LIMIT)
        timed_out("the outputs to park after run was cleared");
    end
  end
  endtask

  task automatic clear_trace();
  begin
    width_q.delete();
    gap_q.delete();
    seg_val_q.delete();
    seg_len_q.delete();
    fall_valid = 1'b0;
  end
  endtask

  ////////////////////
  // stimulus
  initial
  begin
    logic [31:0] data;
    logic [31:0] w;
    logic [11:0] addr;
    logic        err;
    int unsigned rises_at_write;
    int unsigned chg_at_write;
    int unsigned last_fall;

    clk = 1'b0;
    reset_n = 1'b1;
    paddr_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    pwdata_i = '0;
    errors = 0;
    timeouts = 0;
    cyc = 0;
    rise_cnt = 0;
    rise_t = 0;
    fall_t = 0;
    fall_valid = 1'b0;
    az_chg_cnt = 0;
    seg_start = 0;
    prev_pc = sa_pkg::SW_PC_BOOT;
    prev_az = sa_pkg::AZMUX_PC_OUT;
    prev_led = 1'b0;
    pre_v = 0;
    samp_v = 0;
    void'($urandom(8));

    repeat (10) @(posedge clk);
    reset_n <= 1'b0;
    @(negedge clk);

    // outputs and registers out of reset
    check_switch("switch after reset", '{pc: sw_pc_ctl_o, azmux: azmux_o},
                 '{pc: sa_pkg::SW_PC_BOOT, azmux: sa_pkg::AZMUX_PC_OUT});
    check_bit("led0_o after reset", led0_o, 1'b0);
    check_word("monitor_o after reset", {24'b0, monitor_o}, 32'h0);
    for (int a = 0; a < 16; a += 4)
    begin
      apb_read(a[11:0], data, err);
      check_word("register after reset", data, 32'h0);
      check_bit("pslverr_o on reset read", err, 1'b0);
    end

    // random register traffic with run held low
    for (int k = 0; k < 8; k++)
    begin
      w = $urandom() & 32'h0000_00F2;
      apb_write(sa_pkg::REG_CTRL, w, err);
      check_bit("pslverr_o on ctrl write", err, 1'b0);
      apb_read(sa_pkg::REG_CTRL, data, err);
      check_word("ctrl readback", data, w);
      w = $urandom();
      apb_write(sa_pkg::REG_SAMPLE, w, err);
      apb_read(sa_pkg::REG_SAMPLE, data, err);
      check_word("sample readback", data, w);
      w = $urandom();
      apb_write(sa_pkg::REG_PRECHARGE, w, err);
      apb_read(sa_pkg::REG_PRECHARGE, data, err);
      check_word("precharge readback", data, w & 32'h00FF_FFFF);
      apb_write(sa_pkg::REG_STATUS, $urandom(), err);
      check_bit("pslverr_o on status write", err, 1'b1);
      addr = 12'($urandom() % 4000) + 12'h010;
      apb_read(addr, data, err);
      check_bit("pslverr_o on unmapped read", err, 1'b1);
      apb_write(addr, $urandom(), err);
      check_bit("pslverr_o on unmapped write", err, 1'b1);
    end

    ////////////////////
    // charge-test mode
    pre_v  = $urandom() % 6;
    samp_v = $urandom() % 6;
    lo_v   = 4'($urandom() % 8);
    apb_write(sa_pkg::REG_SAMPLE, samp_v, err);
    apb_write(sa_pkg::REG_PRECHARGE, pre_v, err);
    @(negedge clk);
    clear_trace();
    chg_at_write = az_chg_cnt;
    apb_write(sa_pkg::REG_CTRL, ctrl_word(1'b1, sa_pkg::MODE_PC_TEST, lo_v), err);
    wait_widths(3);
    foreach (width_q[i])
      check_word("SIGNAL width", width_q[i], samp_v + 2);
    // reprotect, lo, end and settle between two hi phases
    foreach (gap_q[i])
      check_word("BOOT gap", gap_q[i], 2 * pre_v + samp_v + 7);
    check_word("azmux changes in charge-test", az_chg_cnt, chg_at_write);

    // switch to auto-zero just after a hi phase begins
    wait_rise(rise_cnt);
    rises_at_write = rise_cnt;
    chg_at_write   = az_chg_cnt;
    apb_write(sa_pkg::REG_CTRL, ctrl_word(1'b1, sa_pkg::MODE_AZ, lo_v), err);
    wait_az_change(chg_at_write);
    last_fall = fall_t;
    clear_trace();
    check_word("rises before new owner", rise_cnt, rises_at_write);
    // old cycle ends, then grant, start and protect load
    check_word("mode switch latency", cyc - last_fall, pre_v + samp_v + 6);
    check_word("first AZ mux value", {28'b0, azmux_o}, {28'b0, lo_v});
    apb_read(sa_pkg::REG_STATUS, data, err);
    check_bit("owner in STATUS", data[0], sa_pkg::MODE_AZ);

    ////////////////////
    // auto-zero mode
    wait_widths(3);
    foreach (width_q[i])
      check_word("AZ SIGNAL width", width_q[i], samp_v + 2);
    foreach (gap_q[i])
      check_word("AZ BOOT gap", gap_q[i], 2 * pre_v + samp_v + 7);
    foreach (seg_len_q[i])
    begin
      if (i == 0)
      begin
        check_word("protect lo value", {28'b0, seg_val_q[i]}, {28'b0, lo_v});
        check_word("protect lo length", seg_len_q[i], pre_v + 2);
      end
      else if (i % 2 == 1)
      begin
        check_word("PC_OUT value", {28'b0, seg_val_q[i]}, {28'b0, sa_pkg::AZMUX_PC_OUT});
        check_word("PC_OUT length", seg_len_q[i], 2 * pre_v + samp_v + 6);
      end
      else
      begin
        check_word("lo value", {28'b0, seg_val_q[i]}, {28'b0, lo_v});
        check_word("lo length", seg_len_q[i], samp_v + 3);
      end
    end

    // clear run, the cycle in flight completes first
    apb_write(sa_pkg::REG_CTRL, ctrl_word(1'b0, sa_pkg::MODE_AZ, lo_v), err);
    wait_idle();
    check_switch("switch after stop", '{pc: sw_pc_ctl_o, azmux: azmux_o},
                 '{pc: sa_pkg::SW_PC_BOOT, azmux: sa_pkg::AZMUX_PC_OUT});
    rises_at_write = rise_cnt;
    repeat (4 * (pre_v + samp_v + 10)) @(negedge clk);
    check_word("pulses after stop", rise_cnt, rises_at_write);
    // one hi phase per completed cycle
    apb_read(sa_pkg::REG_STATUS, data, err);
    check_word("STATUS", data, {rise_cnt[15:0], 15'b0, 1'b1});

    finish_run();
  end

endmodule

// File: src.f
hw/sa_pkg.sv
hw/sa_apb_regs.sv
hw/sa_pc_sequencer.sv
hw/sa_az_sequencer.sv
hw/sa_switch_arbiter.sv
hw/sa_top.sv
tb/sa_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= sa_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
